// ==== hw/io_arb_macros.svh ====
`ifndef IO_ARB_MACROS_SVH
`define IO_ARB_MACROS_SVH

// Request sources
`define IO_NUM_REQS       4
`define IO_REQS_BITS      2

// Lanes per request
`define IO_NUM_LANES      2

// Word geometry
`define IO_WORD_SIZE      4
`define IO_WORD_WIDTH     (`IO_WORD_SIZE * 8)
`define IO_ADDR_WIDTH     30

// Tags, source index sits in the low bits at the device
`define IO_TAG_IN_WIDTH   4
`define IO_TAG_OUT_WIDTH  (`IO_TAG_IN_WIDTH + `IO_REQS_BITS)

`define IO_DEV_DEPTH      64
`define IO_DEV_ADDR_BITS  6

`endif

// ==== hw/io_pkg.sv ====
`include "io_arb_macros.svh"

package io_pkg;

    // ########################################################################
    // Lane level fields
    // ########################################################################

    typedef logic [`IO_NUM_LANES-1:0]  io_lane_mask_t;
    typedef logic [`IO_ADDR_WIDTH-1:0] io_addr_t;      // Word address
    typedef logic [`IO_WORD_SIZE-1:0]  io_byteen_t;
    typedef logic [`IO_WORD_WIDTH-1:0] io_word_t;

    // ########################################################################
    // Requests
    // ########################################################################

    // Source side, as issued by a requester
    typedef struct packed {
        io_lane_mask_t                  mask;     // Nonzero means valid
        logic [`IO_TAG_IN_WIDTH-1:0]    tag;
        io_addr_t [`IO_NUM_LANES-1:0]   addr;
        logic                           rw;       // 1 = write
        io_byteen_t [`IO_NUM_LANES-1:0] byteen;
        io_word_t [`IO_NUM_LANES-1:0]   data;
    } io_src_req_t;

    // Device side, tag carries the source index
    typedef struct packed {
        io_lane_mask_t                  mask;
        logic [`IO_TAG_OUT_WIDTH-1:0]   tag;
        io_addr_t [`IO_NUM_LANES-1:0]   addr;
        logic                           rw;
        io_byteen_t [`IO_NUM_LANES-1:0] byteen;
        io_word_t [`IO_NUM_LANES-1:0]   data;
    } io_dev_req_t;

    // ########################################################################
    // Responses
    // ########################################################################

    typedef struct packed {
        logic [`IO_TAG_IN_WIDTH-1:0]  tag;
        io_word_t                     data;
    } io_src_rsp_t;

    typedef struct packed {
        logic [`IO_TAG_OUT_WIDTH-1:0] tag;
        io_word_t                     data;
    } io_dev_rsp_t;

endpackage

// ==== hw/io_skid_buffer.sv ====
module io_skid_buffer
    import io_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  logic        valid_in,
    input  io_src_req_t data_in,
    output logic        ready_in,

    output logic        valid_out,
    output io_src_req_t data_out,
    input  logic        ready_out
);

    logic        main_valid;
    logic        skid_valid;
    logic        ready_q;
    io_src_req_t main_data;
    io_src_req_t skid_data;

    logic push;
    logic pop;
    logic to_main;
    logic to_skid;

    assign push = valid_in && ready_q;
    assign pop  = main_valid && ready_out;

    // Input lands in main unless main is held
    assign to_main = push && (!main_valid || pop);
    assign to_skid = push && main_valid && !pop;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
            ready_q    <= 1'b0;
        end else begin
            if (to_main) begin
                main_valid <= 1'b1;
            end else if (pop) begin
                main_valid <= skid_valid;  // Skid moves up
            end
            if (to_skid) begin
                skid_valid <= 1'b1;
            end else if (pop) begin
                skid_valid <= 1'b0;
            end
            ready_q <= !(to_skid || (skid_valid && !pop));
        end
    end

    always_ff @(posedge clk) begin
        if (to_main) begin
            main_data <= data_in;
        end else if (pop && skid_valid) begin
            main_data <= skid_data;
        end
        if (to_skid) begin
            skid_data <= data_in;
        end
    end

    assign ready_in  = ready_q;
    assign valid_out = main_valid;
    assign data_out  = main_data;

endmodule

// ==== hw/io_stream_arbiter.sv ====
`include "io_arb_macros.svh"

module io_stream_arbiter
    import io_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,

    input  logic [`IO_NUM_REQS-1:0]        valid_in,
    input  io_dev_req_t [`IO_NUM_REQS-1:0] data_in,
    output logic [`IO_NUM_REQS-1:0]        ready_in,

    output logic                           valid_out,
    output io_dev_req_t                    data_out,
    input  logic                           ready_out
);

    localparam int NUM_REQS  = `IO_NUM_REQS;
    localparam int REQS_BITS = `IO_REQS_BITS;

    logic [REQS_BITS-1:0] prio_ptr;   // Highest priority source
    logic [REQS_BITS-1:0] grant;
    logic [REQS_BITS-1:0] held_grant;
    logic                 held;       // Stalled transfer keeps its grant
    logic                 any_valid;
    logic                 fire;

    // ########################################################################
    // Round-robin search from the priority pointer
    // ########################################################################

    always_comb begin
        int cand;
        grant     = prio_ptr;
        any_valid = 1'b0;
        // Walk backwards so the nearest valid source wins
        for (int k = NUM_REQS - 1; k >= 0; k--) begin
            cand = (int'(prio_ptr) + k) % NUM_REQS;
            if (valid_in[cand]) begin
                grant     = REQS_BITS'(cand);
                any_valid = 1'b1;
            end
        end
        if (held) begin
            grant     = held_grant;
            any_valid = valid_in[held_grant];
        end
    end

    assign valid_out = any_valid;
    assign data_out  = data_in[grant];
    assign fire      = any_valid && ready_out;

    always_comb begin
        ready_in = '0;
        ready_in[grant] = fire;
    end

    // ########################################################################
    // Pointer update, only on a transfer
    // ########################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prio_ptr <= '0;
        end else if (fire) begin
            if (grant == REQS_BITS'(NUM_REQS - 1)) begin
                prio_ptr <= '0;
            end else begin
                prio_ptr <= grant + 1'b1;
            end
        end
    end

    // Offered request stays put until the device takes it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held       <= 1'b0;
            held_grant <= '0;
        end else begin
            held       <= any_valid && !ready_out;
            held_grant <= grant;
        end
    end

endmodule

// ==== hw/io_arb.sv ====
`include "io_arb_macros.svh"

module io_arb
    import io_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,

    // Source requests
    input  io_src_req_t [`IO_NUM_REQS-1:0] src_req,
    output logic [`IO_NUM_REQS-1:0]        src_ready,

    // Device request
    output logic                           dev_req_valid,
    output io_dev_req_t                    dev_req,
    input  logic                           dev_req_ready,

    // Source responses, payload shared by all sources
    output logic [`IO_NUM_REQS-1:0]        src_rsp_valid,
    output io_src_rsp_t                    src_rsp,
    input  logic [`IO_NUM_REQS-1:0]        src_rsp_ready,

    // Device response
    input  logic                           dev_rsp_valid,
    input  io_dev_rsp_t                    dev_rsp,
    output logic                           dev_rsp_ready
);

    localparam int NUM_REQS  = `IO_NUM_REQS;
    localparam int REQS_BITS = `IO_REQS_BITS;

    logic [NUM_REQS-1:0]        src_valid;
    logic [NUM_REQS-1:0]        buf_valid;
    io_src_req_t [NUM_REQS-1:0] buf_data;
    logic [NUM_REQS-1:0]        buf_ready;
    io_dev_req_t [NUM_REQS-1:0] arb_data;

    // ########################################################################
    // Per-source buffering and tag extension
    // ########################################################################

    for (genvar i = 0; i < NUM_REQS; i++) begin : g_src
        assign src_valid[i] = |src_req[i].mask;

        io_skid_buffer req_buf (
            .clk       (clk),
            .rst_n     (rst_n),
            .valid_in  (src_valid[i]),
            .data_in   (src_req[i]),
            .ready_in  (src_ready[i]),
            .valid_out (buf_valid[i]),
            .data_out  (buf_data[i]),
            .ready_out (buf_ready[i])
        );

        assign arb_data[i].mask   = buf_data[i].mask;
        assign arb_data[i].tag    = {buf_data[i].tag, REQS_BITS'(i)};  // Index in low bits
        assign arb_data[i].addr   = buf_data[i].addr;
        assign arb_data[i].rw     = buf_data[i].rw;
        assign arb_data[i].byteen = buf_data[i].byteen;
        assign arb_data[i].data   = buf_data[i].data;
    end

    io_stream_arbiter req_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (buf_valid),
        .data_in   (arb_data),
        .ready_in  (buf_ready),
        .valid_out (dev_req_valid),
        .data_out  (dev_req),
        .ready_out (dev_req_ready)
    );

    // ########################################################################
    // Response steering by tag
    // ########################################################################

    logic [REQS_BITS-1:0] rsp_sel;

    assign rsp_sel = dev_rsp.tag[REQS_BITS-1:0];

    always_comb begin
        src_rsp_valid = '0;
        src_rsp_valid[rsp_sel] = dev_rsp_valid;
    end

    assign src_rsp.tag   = dev_rsp.tag[REQS_BITS +: `IO_TAG_IN_WIDTH];  // Strip index
    assign src_rsp.data  = dev_rsp.data;
    assign dev_rsp_ready = src_rsp_ready[rsp_sel];

endmodule

// ==== hw/io_mem_device.sv ====
`include "io_arb_macros.svh"

module io_mem_device
    import io_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  logic        req_valid,
    input  io_dev_req_t req,
    output logic        req_ready,

    output logic        rsp_valid,
    output io_dev_rsp_t rsp,
    input  logic        rsp_ready
);

    localparam int DEPTH         = `IO_DEV_DEPTH;
    localparam int DEV_ADDR_BITS = `IO_DEV_ADDR_BITS;
    localparam int NUM_LANES     = `IO_NUM_LANES;
    localparam int WORD_SIZE     = `IO_WORD_SIZE;

    io_word_t mem [DEPTH];

    logic                     req_fire;
    logic                     wr_fire;
    logic                     rd_fire;
    logic [DEV_ADDR_BITS-1:0] rd_addr;
    logic                     rsp_valid_q;
    io_dev_rsp_t              rsp_q;

    // Held response blocks any new request
    assign req_ready = !rsp_valid_q;
    assign req_fire  = req_valid && req_ready;
    assign wr_fire   = req_fire && req.rw;
    assign rd_fire   = req_fire && !req.rw;

    // Lowest active lane supplies the read address
    always_comb begin
        rd_addr = req.addr[0][DEV_ADDR_BITS-1:0];
        for (int l = NUM_LANES - 1; l >= 0; l--) begin
            if (req.mask[l]) begin
                rd_addr = req.addr[l][DEV_ADDR_BITS-1:0];
            end
        end
    end

    // ########################################################################
    // Scratch memory, byte masked lane writes
    // ########################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < DEPTH; w++) begin
                mem[w] <= '0;
            end
        end else if (wr_fire) begin
            // Later lanes overwrite earlier ones on a shared word
            for (int l = 0; l < NUM_LANES; l++) begin
                for (int b = 0; b < WORD_SIZE; b++) begin
                    if (req.mask[l] && req.byteen[l][b]) begin
                        mem[req.addr[l][DEV_ADDR_BITS-1:0]][b*8 +: 8] <= req.data[l][b*8 +: 8];
                    end
                end
            end
        end
    end

    // ########################################################################
    // Read response
    // ########################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid_q <= 1'b0;
        end else if (rd_fire) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rsp_q.tag  <= req.tag;
            rsp_q.data <= mem[rd_addr];
        end
    end

    assign rsp_valid = rsp_valid_q;
    assign rsp       = rsp_q;

endmodule

// ==== hw/io_subsys_top.sv ====
`include "io_arb_macros.svh"

module io_subsys_top
    import io_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,

    input  io_src_req_t [`IO_NUM_REQS-1:0] src_req,
    output logic [`IO_NUM_REQS-1:0]        src_ready,

    output logic [`IO_NUM_REQS-1:0]        src_rsp_valid,
    output io_src_rsp_t                    src_rsp,
    input  logic [`IO_NUM_REQS-1:0]        src_rsp_ready
);

    logic        dev_req_valid;
    io_dev_req_t dev_req;
    logic        dev_req_ready;
    logic        dev_rsp_valid;
    io_dev_rsp_t dev_rsp;
    logic        dev_rsp_ready;

    io_arb arb (
        .clk           (clk),
        .rst_n         (rst_n),
        .src_req       (src_req),
        .src_ready     (src_ready),
        .dev_req_valid (dev_req_valid),
        .dev_req       (dev_req),
        .dev_req_ready (dev_req_ready),
        .src_rsp_valid (src_rsp_valid),
        .src_rsp       (src_rsp),
        .src_rsp_ready (src_rsp_ready),
        .dev_rsp_valid (dev_rsp_valid),
        .dev_rsp       (dev_rsp),
        .dev_rsp_ready (dev_rsp_ready)
    );

    io_mem_device dev (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (dev_req_valid),
        .req       (dev_req),
        .req_ready (dev_req_ready),
        .rsp_valid (dev_rsp_valid),
        .rsp       (dev_rsp),
        .rsp_ready (dev_rsp_ready)
    );

endmodule

// ==== dv/io_subsys_assert.sv ====
`include "io_arb_macros.svh"

module io_subsys_assert
    import io_pkg::*;
(
    input logic                    clk,
    input logic                    rst_n,
    input logic                    dev_req_valid,
    input io_dev_req_t             dev_req,
    input logic                    dev_req_ready,
    input logic [`IO_NUM_REQS-1:0] src_rsp_valid,
    input io_src_rsp_t             src_rsp,
    input logic [`IO_NUM_REQS-1:0] src_rsp_ready
);

    // Stalled device request stays up with the same payload
    dev_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        dev_req_valid && !dev_req_ready |=> dev_req_valid && $stable(dev_req))
        else $error("device request changed while the device stalled");

    rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (src_rsp_valid & ~src_rsp_ready) != '0 |=> $stable(src_rsp_valid) && $stable(src_rsp))
        else $error("stalled response changed before it was taken");

    rsp_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(src_rsp_valid))
        else $error("response valid raised for more than one source");

endmodule

bind io_arb io_subsys_assert arb_checks (
    .clk           (clk),
    .rst_n         (rst_n),
    .dev_req_valid (dev_req_valid),
    .dev_req       (dev_req),
    .dev_req_ready (dev_req_ready),
    .src_rsp_valid (src_rsp_valid),
    .src_rsp       (src_rsp),
    .src_rsp_ready (src_rsp_ready)
);

// ==== dv/io_subsys_tb.sv ====
`include "io_arb_macros.svh"

module io_subsys_tb
    import io_pkg::*;
();

    localparam int NUM_REQS   = `IO_NUM_REQS;
    localparam int TAG_W      = `IO_TAG_IN_WIDTH;
    localparam int NUM_OPS    = 14;
    localparam int FIELDS     = 11;
    localparam int CLK_PERIOD = 4;

    // Columns of one op line
    localparam int F_SRC   = 0;
    localparam int F_MASK  = 1;
    localparam int F_RW    = 2;
    localparam int F_ADDR0 = 3;
    localparam int F_ADDR1 = 4;
    localparam int F_BE0   = 5;
    localparam int F_BE1   = 6;
    localparam int F_DATA0 = 7;
    localparam int F_DATA1 = 8;
    localparam int F_TAG   = 9;
    localparam int F_EXP   = 10;

    logic                       clk = 1'b0;
    logic                       rst_n = 1'b0;
    io_src_req_t [NUM_REQS-1:0] src_req = '0;
    logic [NUM_REQS-1:0]        src_ready;
    logic [NUM_REQS-1:0]        src_rsp_valid;
    io_src_rsp_t                src_rsp;
    logic [NUM_REQS-1:0]        src_rsp_ready = '0;

    logic [31:0]                op_table [NUM_OPS*FIELDS];
    io_src_req_t [NUM_REQS-1:0] next_req;
    logic [NUM_REQS-1:0]        next_rsp_ready;
    int                         op_ptr [NUM_REQS];    // Next op to issue
    int                         rd_ptr [NUM_REQS];    // Next read to be answered
    int                         idle_cnt [NUM_REQS];
    int                         issued [NUM_REQS];
    int                         received [NUM_REQS];
    int                         errors = 0;

    io_subsys_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .src_req       (src_req),
        .src_ready     (src_ready),
        .src_rsp_valid (src_rsp_valid),
        .src_rsp       (src_rsp),
        .src_rsp_ready (src_rsp_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ##########################################################################
    // Op table access
    // ##########################################################################

    function automatic logic [31:0] col_value(int op, int col);
        return op_table[op * FIELDS + col];
    endfunction

    function automatic int find_op(int s, int from, bit reads_only);
        for (int op = from; op < NUM_OPS; op++) begin
            if (col_value(op, F_SRC) == s && (!reads_only || col_value(op, F_RW) == 0)) begin
                return op;
            end
        end
        return NUM_OPS;
    endfunction

    function automatic int count_reads(int s);
        int n;
        n = 0;
        for (int op = 0; op < NUM_OPS; op++) begin
            if (col_value(op, F_SRC) == s && col_value(op, F_RW) == 0) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic io_src_req_t build_req(int op);
        io_src_req_t r;
        r.mask      = io_lane_mask_t'(col_value(op, F_MASK));
        r.tag       = TAG_W'(col_value(op, F_TAG));
        r.addr[0]   = io_addr_t'(col_value(op, F_ADDR0));
        r.addr[1]   = io_addr_t'(col_value(op, F_ADDR1));
        r.rw        = col_value(op, F_RW) != 0;
        r.byteen[0] = io_byteen_t'(col_value(op, F_BE0));
        r.byteen[1] = io_byteen_t'(col_value(op, F_BE1));
        r.data[0]   = col_value(op, F_DATA0);
        r.data[1]   = col_value(op, F_DATA1);
        return r;
    endfunction

    function automatic bit sources_finished();
        for (int s = 0; s < NUM_REQS; s++) begin
            if (op_ptr[s] < NUM_OPS || received[s] < issued[s]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // ##########################################################################
    // Checking and per-cycle source behavior
    // ##########################################################################

    task automatic compare_word(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_response(int s);
        string name;
        if (received[s] >= issued[s] || rd_ptr[s] >= NUM_OPS) begin
            $display("Source %0d received a response with no read outstanding", s);
            errors++;
        end else begin
            name = $sformatf("src%0d_op%0d", s, rd_ptr[s]);
            compare_word({name, "_tag"}, col_value(rd_ptr[s], F_TAG), 32'(src_rsp.tag));
            compare_word({name, "_data"}, col_value(rd_ptr[s], F_EXP), src_rsp.data);
            received[s]++;
            rd_ptr[s] = find_op(s, rd_ptr[s] + 1, 1'b1);
        end
    endtask

    // Uses values sampled at the current edge, fills next_req and next_rsp_ready
    task automatic advance_sources();
        if ($countones(src_rsp_valid) > 1) begin
            $display("More than one source saw a response valid in the same cycle");
            errors++;
        end
        for (int s = 0; s < NUM_REQS; s++) begin
            if (src_rsp_valid[s] && src_rsp_ready[s]) begin
                check_response(s);
            end
            if (src_req[s].mask != '0 && src_ready[s]) begin
                if (!src_req[s].rw) begin
                    issued[s]++;
                end
                op_ptr[s]   = find_op(s, op_ptr[s] + 1, 1'b0);
                idle_cnt[s] = $urandom % 3;  // Gap before the next op
            end
            if (idle_cnt[s] > 0) begin
                idle_cnt[s]--;
                next_req[s] = '0;
            end else if (op_ptr[s] < NUM_OPS) begin
                next_req[s] = build_req(op_ptr[s]);
            end else begin
                next_req[s] = '0;
            end
            next_rsp_ready[s] = ($urandom % 4) != 0;
        end
    endtask

    initial begin
        int drain;
        void'($urandom(32'he76f_2dbf));
        $readmemh("dv/io_golden.hex", op_table);
        for (int s = 0; s < NUM_REQS; s++) begin
            op_ptr[s]   = find_op(s, 0, 1'b0);
            rd_ptr[s]   = find_op(s, 0, 1'b1);
            idle_cnt[s] = 0;
            issued[s]   = 0;
            received[s] = 0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // Quiet window after reset
        repeat (10) begin
            @(posedge clk);
            if (src_rsp_valid != '0) begin
                $display("Response valid seen after reset with no request issued");
                errors++;
            end
        end

        drain = 10;  // Extra cycles to catch stray responses
        while (drain > 0) begin
            @(posedge clk);
            advance_sources();
            src_req       <= next_req;
            src_rsp_ready <= next_rsp_ready;
            if (sources_finished()) begin
                drain--;
            end
        end

        for (int s = 0; s < NUM_REQS; s++) begin
            compare_word($sformatf("src%0d_read_count", s), 32'(count_reads(s)),
                         32'(received[s]));
        end
        $display("Total errors: %0d", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * NUM_OPS * 50);
        $display("Watchdog expired before all responses came back");
        $display("Total errors: %0d", errors + 1);
        $display("Errors found");
        $finish;
    end

endmodule

// ==== dv/io_golden.hex ====
// src mask rw addr0 addr1 be0 be1 data0 data1 tag expected_read
// Source s keeps to word region 16*s so the sources never interfere
0 3 1 01 02 f f 11111111 22222222 1 00000000
0 2 0 01 02 0 0 00000000 00000000 2 22222222
0 1 0 01 02 0 0 00000000 00000000 3 11111111
1 3 1 10 10 3 6 aaaaaaaa bbbbbbbb 4 00000000
1 1 0 10 00 0 0 00000000 00000000 5 00bbbbaa
1 1 1 11 11 8 f 12345678 ffffffff 6 00000000
1 3 0 11 10 0 0 00000000 00000000 7 12000000
2 3 1 20 21 f f cafef00d 0badbeef 8 00000000
2 2 0 20 21 0 0 00000000 00000000 9 0badbeef
2 1 0 20 21 0 0 00000000 00000000 a cafef00d
3 1 1 7f 30 f 0 5a5a5a5a 00000000 b 00000000
3 1 0 3f 00 0 0 00000000 00000000 c 5a5a5a5a
3 3 0 30 3f 0 0 00000000 00000000 d 00000000
3 2 0 00 3f 0 0 00000000 00000000 e 5a5a5a5a

// ==== src.f ====
+incdir+hw
hw/io_pkg.sv
hw/io_skid_buffer.sv
hw/io_stream_arbiter.sv
hw/io_arb.sv
hw/io_mem_device.sv
hw/io_subsys_top.sv
dv/io_subsys_assert.sv
dv/io_subsys_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := io_subsys_tb
FILELIST := src.f
LOG      := sim.log
FAIL_MSG := Errors found

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
